// ==== project.f ====
rtl/armPkg.sv
rtl/instrDecoder.sv
rtl/condUnit.sv
rtl/pcUnit.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/datapath.sv
rtl/armCore.sv
verification/tbClock.sv
verification/tbMemory.sv
verification/armCoreTb.sv

// ==== rtl/armCore.sv ====
`timescale 1ns/1ps

module armCore import armPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  instrWord             Instr,
   input  logic [dataWidth-1:0] ReadData,
   input  logic                 PCReady,      // Retire enable
   output logic [dataWidth-1:0] PC,
   output logic                 MemWrite,
   output logic [dataWidth-1:0] ALUResult,
   output logic [dataWidth-1:0] WriteData,
   output logic                 MemStrobe
);

   // Unconditioned controls from the decoder
   logic [1:0] flagWrite;
   logic       branch, regWrite, memWrite, memStrobe;
   logic       memToReg, aluSrcImm, regBSelRd;
   logic [1:0] immSrc, aluSel;

   // After the condition check
   logic       pcSrc, regWriteEn;
   logic [3:0] aluFlags;

   instrDecoder decoder (
      .instr(Instr), .flagWrite(flagWrite), .branch(branch),
      .regWrite(regWrite), .memWrite(memWrite), .memStrobe(memStrobe),
      .memToReg(memToReg), .aluSrcImm(aluSrcImm), .regBSelRd(regBSelRd),
      .immSrc(immSrc), .aluSel(aluSel)
   );

   condUnit cond (
      .clk(clk), .reset(reset), .cond(Instr.dp.cond), .aluFlags(aluFlags),
      .flagWrite(flagWrite), .branch(branch), .regWrite(regWrite),
      .memWrite(memWrite), .memStrobe(memStrobe), .PCReady(PCReady),
      .pcSrc(pcSrc), .regWriteEn(regWriteEn), .MemWrite(MemWrite),
      .MemStrobe(MemStrobe)
   );

   datapath dp (
      .clk(clk), .reset(reset), .instr(Instr), .pcSrc(pcSrc), .branch(branch),
      .regWriteEn(regWriteEn), .regBSelRd(regBSelRd), .immSrc(immSrc),
      .aluSrcImm(aluSrcImm), .aluSel(aluSel), .memToReg(memToReg),
      .PCReady(PCReady), .ReadData(ReadData), .PC(PC), .ALUResult(ALUResult),
      .WriteData(WriteData), .aluFlags(aluFlags)
   );

endmodule

// ==== rtl/armPkg.sv ====
package armPkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;
   localparam logic [3:0] pcRegIndex = 4'd15;   // Reads as PC+8

   // Op field, instr[27:26]
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory   = 2'b01;
   localparam logic [1:0] opBranch   = 2'b10;

   // Data-processing commands, instr[24:21]
   localparam logic [3:0] cmdAnd = 4'b0000;
   localparam logic [3:0] cmdSub = 4'b0010;
   localparam logic [3:0] cmdAdd = 4'b0100;
   localparam logic [3:0] cmdOrr = 4'b1100;

   localparam logic [1:0] aluSelAdd = 2'b00;
   localparam logic [1:0] aluSelSub = 2'b01;   // Bit 0 inverts B and carries in
   localparam logic [1:0] aluSelAnd = 2'b10;
   localparam logic [1:0] aluSelOrr = 2'b11;

   // Immediate kinds
   localparam logic [1:0] immByte   = 2'b00;   // imm8, zero extended
   localparam logic [1:0] immTwelve = 2'b01;   // imm12, zero extended
   localparam logic [1:0] immBranch = 2'b10;   // imm24, sign extended, word offset

   // Condition codes, 1111 not used
   localparam logic [3:0] condEq = 4'b0000;
   localparam logic [3:0] condNe = 4'b0001;
   localparam logic [3:0] condCs = 4'b0010;
   localparam logic [3:0] condCc = 4'b0011;
   localparam logic [3:0] condMi = 4'b0100;
   localparam logic [3:0] condPl = 4'b0101;
   localparam logic [3:0] condVs = 4'b0110;
   localparam logic [3:0] condVc = 4'b0111;
   localparam logic [3:0] condHi = 4'b1000;
   localparam logic [3:0] condLs = 4'b1001;
   localparam logic [3:0] condGe = 4'b1010;
   localparam logic [3:0] condLt = 4'b1011;
   localparam logic [3:0] condGt = 4'b1100;
   localparam logic [3:0] condLe = 4'b1101;
   localparam logic [3:0] condAl = 4'b1110;

   // Flag bit positions
   localparam int flagN = 3;
   localparam int flagZ = 2;
   localparam int flagC = 1;
   localparam int flagV = 0;

   // Two views of one instruction word
   typedef union packed {
      struct packed {
         logic [3:0]  cond;
         logic [1:0]  op;
         logic        immBit;    // I for data processing
         logic [3:0]  cmd;
         logic        sBit;      // S, or L for memory
         logic [3:0]  rn;
         logic [3:0]  rd;
         logic [11:0] operand;   // imm8, rm or imm12
      } dp;
      struct packed {
         logic [3:0]  cond;
         logic [1:0]  op;
         logic [1:0]  funct;     // 10 for B, 11 is BL
         logic [23:0] imm24;
      } br;
   } instrWord;

endpackage

// ==== rtl/condUnit.sv ====
`timescale 1ns/1ps

module condUnit import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] cond,
   input  logic [3:0] aluFlags,
   input  logic [1:0] flagWrite,
   input  logic       branch,
   input  logic       regWrite,
   input  logic       memWrite,
   input  logic       memStrobe,
   input  logic       PCReady,
   output logic       pcSrc,
   output logic       regWriteEn,
   output logic       MemWrite,
   output logic       MemStrobe
);

   logic [1:0] nzFlags, cvFlags;   // Stored {N,Z} and {C,V}
   logic       neg, zero, carry, overflow, ge;
   logic       condEx, pass, retire;

   assign {neg, zero}      = nzFlags;
   assign {carry, overflow} = cvFlags;
   assign ge = (neg == overflow);

   always_comb
      case (cond)
         condEq:  condEx = zero;
         condNe:  condEx = ~zero;
         condCs:  condEx = carry;
         condCc:  condEx = ~carry;
         condMi:  condEx = neg;
         condPl:  condEx = ~neg;
         condVs:  condEx = overflow;
         condVc:  condEx = ~overflow;
         condHi:  condEx = carry & ~zero;
         condLs:  condEx = ~carry | zero;
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~zero & ge;
         condLe:  condEx = zero | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;   // 1111 never executes
      endcase

   assign pass   = condEx & ~reset;
   assign retire = pass & PCReady;   // State may change this edge

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         nzFlags <= 2'b00;
         cvFlags <= 2'b00;
      end
      else
      begin
         if (flagWrite[1] && retire) nzFlags <= {aluFlags[flagN], aluFlags[flagZ]};
         if (flagWrite[0] && retire) cvFlags <= {aluFlags[flagC], aluFlags[flagV]};
      end
   end

   assign pcSrc      = branch & pass;   // PC register already waits on PCReady
   assign regWriteEn = regWrite & retire;
   assign MemWrite   = memWrite & retire;
   assign MemStrobe  = memStrobe & pass;   // Not held off by a stall

endmodule

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps

module datapath import armPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  instrWord             instr,
   input  logic                 pcSrc,
   input  logic                 branch,
   input  logic                 regWriteEn,
   input  logic                 regBSelRd,
   input  logic [1:0]           immSrc,
   input  logic                 aluSrcImm,
   input  logic [1:0]           aluSel,
   input  logic                 memToReg,
   input  logic                 PCReady,
   input  logic [dataWidth-1:0] ReadData,
   output logic [dataWidth-1:0] PC,
   output logic [dataWidth-1:0] ALUResult,
   output logic [dataWidth-1:0] WriteData,
   output logic [3:0]           aluFlags
);

   logic [regAddrWidth-1:0] regAddrA, regAddrB;
   logic [dataWidth-1:0]    pcPlus8, srcA, result;

   // Branch target is PC+8 plus offset, so A reads R15
   assign regAddrA = branch ? pcRegIndex : instr.dp.rn;
   // STR data comes from rd, register operand from rm
   assign regAddrB = regBSelRd ? instr.dp.rd : instr.dp.operand[3:0];

   assign result = memToReg ? ReadData : ALUResult;   // LDR writes loaded word

   pcUnit pcu (
      .clk(clk), .reset(reset), .advance(PCReady), .pcSrc(pcSrc),
      .branchTarget(ALUResult), .PC(PC), .pcPlus8(pcPlus8)
   );

   regFile rf (
      .clk(clk), .writeEn(regWriteEn), .readAddrA(regAddrA),
      .readAddrB(regAddrB), .writeAddr(instr.dp.rd), .writeData(result),
      .pcPlus8(pcPlus8), .readDataA(srcA), .readDataB(WriteData)
   );

   executeUnit exu (
      .srcA(srcA), .regB(WriteData), .instr(instr), .immSrc(immSrc),
      .aluSrcImm(aluSrcImm), .aluSel(aluSel), .result(ALUResult),
      .aluFlags(aluFlags)
   );

endmodule

// ==== rtl/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import armPkg::*;
(
   input  logic [dataWidth-1:0] srcA,
   input  logic [dataWidth-1:0] regB,
   input  instrWord             instr,
   input  logic [1:0]           immSrc,
   input  logic                 aluSrcImm,
   input  logic [1:0]           aluSel,
   output logic [dataWidth-1:0] result,
   output logic [3:0]           aluFlags
);

   logic [dataWidth-1:0] extImm, srcB, condInvB;
   logic [dataWidth:0]   sum;   // Extra bit is the carry out
   logic                 isSub, isArith;

   // Immediate extension
   always_comb
      case (immSrc)
         immByte:   extImm = {24'b0, instr.dp.operand[7:0]};
         immTwelve: extImm = {20'b0, instr.dp.operand};
         immBranch: extImm = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
         default:   extImm = '0;
      endcase

   assign srcB = aluSrcImm ? extImm : regB;

   assign isSub   = (aluSel == aluSelSub);
   assign isArith = (aluSel == aluSelAdd) || isSub;

   // SUB is A + ~B + 1
   assign condInvB = isSub ? ~srcB : srcB;
   assign sum      = {1'b0, srcA} + {1'b0, condInvB} + {{dataWidth{1'b0}}, isSub};

   always_comb
      case (aluSel)
         aluSelAnd: result = srcA & srcB;
         aluSelOrr: result = srcA | srcB;
         default:   result = sum[dataWidth-1:0];   // ADD or SUB
      endcase

   always_comb
   begin
      aluFlags        = 4'b0000;
      aluFlags[flagN] = result[dataWidth-1];
      aluFlags[flagZ] = (result == '0);
      aluFlags[flagC] = isArith & sum[dataWidth];   // ARM carry, not borrow, on SUB
      // Operands alike in sign after inversion, result sign differs
      aluFlags[flagV] = isArith
                        & ~(srcA[dataWidth-1] ^ srcB[dataWidth-1] ^ isSub)
                        & (srcA[dataWidth-1] ^ sum[dataWidth-1]);
   end

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import armPkg::*;
(
   input  instrWord   instr,
   output logic [1:0] flagWrite,    // [1] N/Z, [0] C/V
   output logic       branch,
   output logic       regWrite,
   output logic       memWrite,
   output logic       memStrobe,
   output logic       memToReg,
   output logic       aluSrcImm,
   output logic       regBSelRd,    // STR reads rd as data
   output logic [1:0] immSrc,
   output logic [1:0] aluSel
);

   logic knownCmd;
   logic arithCmd;

   // ALU decoder
   always_comb
   begin
      knownCmd = 1'b1;
      aluSel   = aluSelAdd;   // Addresses and branch targets add
      if (instr.dp.op == opDataProc)
         case (instr.dp.cmd)
            cmdAdd:  aluSel = aluSelAdd;
            cmdSub:  aluSel = aluSelSub;
            cmdAnd:  aluSel = aluSelAnd;
            cmdOrr:  aluSel = aluSelOrr;
            default: knownCmd = 1'b0;   // Unimplemented command
         endcase
   end

   assign arithCmd = (instr.dp.cmd == cmdAdd) || (instr.dp.cmd == cmdSub);

   // Main decoder
   always_comb
   begin
      // Everything off unless an encoding is recognized
      flagWrite = 2'b00;
      branch    = 1'b0;
      regWrite  = 1'b0;
      memWrite  = 1'b0;
      memStrobe = 1'b0;
      memToReg  = 1'b0;
      aluSrcImm = 1'b0;
      regBSelRd = 1'b0;
      immSrc    = immByte;
      case (instr.dp.op)
         opDataProc:
         begin
            aluSrcImm    = instr.dp.immBit;         // imm8 or rm
            regWrite     = knownCmd;
            flagWrite[1] = knownCmd & instr.dp.sBit;
            flagWrite[0] = knownCmd & instr.dp.sBit & arithCmd;
         end
         opMemory:
            if (!instr.dp.immBit)   // Register offset form not supported
            begin
               aluSrcImm = 1'b1;
               immSrc    = immTwelve;
               memStrobe = 1'b1;
               regWrite  = instr.dp.sBit;    // LDR
               memToReg  = instr.dp.sBit;
               memWrite  = ~instr.dp.sBit;   // STR
               regBSelRd = ~instr.dp.sBit;
            end
         opBranch:
            if (instr.br.funct == 2'b10)   // BL and other functs decode as a no-op
            begin
               branch    = 1'b1;
               aluSrcImm = 1'b1;
               immSrc    = immBranch;
            end
         default: ;   // Op 11 is a no-op
      endcase
   end

endmodule

// ==== rtl/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit import armPkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 advance,        // High on a retiring edge
   input  logic                 pcSrc,
   input  logic [dataWidth-1:0] branchTarget,
   output logic [dataWidth-1:0] PC,
   output logic [dataWidth-1:0] pcPlus8
);

   logic [dataWidth-1:0] pcPlus4, nextPc;

   assign pcPlus4 = PC + 32'd4;
   assign pcPlus8 = pcPlus4 + 32'd4;   // Value seen when reading R15
   assign nextPc  = pcSrc ? branchTarget : pcPlus4;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         PC <= '0;   // Program starts at address 0
      else if (advance)
         PC <= nextPc;
   end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile import armPkg::*;
(
   input  logic                    clk,
   input  logic                    writeEn,
   input  logic [regAddrWidth-1:0] readAddrA,
   input  logic [regAddrWidth-1:0] readAddrB,
   input  logic [regAddrWidth-1:0] writeAddr,
   input  logic [dataWidth-1:0]    writeData,
   input  logic [dataWidth-1:0]    pcPlus8,
   output logic [dataWidth-1:0]    readDataA,
   output logic [dataWidth-1:0]    readDataB
);

   logic [dataWidth-1:0] regs [0:14];   // R0 to R14, R15 lives in the PC unit

   // Writes to R15 are ignored, only B moves the PC
   always_ff @(posedge clk)
   begin
      if (writeEn && writeAddr != pcRegIndex)
         regs[writeAddr] <= writeData;
   end

   assign readDataA = (readAddrA == pcRegIndex) ? pcPlus8 : regs[readAddrA];
   assign readDataB = (readAddrB == pcRegIndex) ? pcPlus8 : regs[readAddrB];

endmodule

// ==== verification/armCoreTb.sv ====
`timescale 1ns/1ps

module armCoreTb;

   logic        clk, reset, PCReady;
   logic [31:0] Instr, ReadData, PC, ALUResult, WriteData;
   logic        MemWrite, MemStrobe;

   logic [15:0] lfsr;
   logic [31:0] prevPc;
   logic        prevReady, prevReset;
   int          storeIdx;
   int          errs [1:6];
   int          cycles, total;

   // Expected stores in program order
   localparam int numStores = 11;
   localparam logic [31:0] storeAddr [0:numStores-1] = '{
      32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h1C,
      32'h20, 32'h2C, 32'h30};
   localparam logic [31:0] storeData [0:numStores-1] = '{
      32'h8, 32'h7, 32'hD, 32'h3, 32'h8, 32'h5, 32'h15, 32'hF,
      32'h71, 32'h0, 32'hFFFF_FE60};
   localparam int storeBehavior [0:numStores-1] = '{3, 3, 3, 3, 3, 3, 3, 3, 4, 5, 6};

   tbClock clkGen (.clk(clk), .reset(reset));

   tbMemory mem (
      .clk(clk), .pc(PC), .addr(ALUResult), .writeData(WriteData),
      .memWrite(MemWrite), .instr(Instr), .readData(ReadData)
   );

   armCore UUT (
      .clk(clk), .reset(reset), .Instr(Instr), .ReadData(ReadData),
      .PCReady(PCReady), .PC(PC), .MemWrite(MemWrite), .ALUResult(ALUResult),
      .WriteData(WriteData), .MemStrobe(MemStrobe)
   );

   // Galois LFSR stepped once per bit taken
   function automatic logic nextBit();
      logic lsb;
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb)
         lfsr = lfsr ^ 16'hB400;
      return lsb;
   endfunction

   // Taken branches of the program
   function automatic logic branchAt(input logic [31:0] pc);
      return pc == 32'h58 || pc == 32'h7C;
   endfunction

   // Addresses of LDR and STR that pass their condition
   function automatic logic memOpAt(input logic [31:0] pc);
      return (pc >= 32'h28 && pc <= 32'h48) || pc == 32'h50 || pc == 32'h68
             || pc == 32'h6C || pc == 32'h74;
   endfunction

   task automatic valueError(input int beh, input string name,
                             input logic [31:0] actual, input logic [31:0] expected);
      $display("** Error: %s = %h, expected %h at %0t", name, actual, expected, $time);
      errs[beh]++;
   endtask

   task automatic plainError(input int beh, input string msg);
      $display("Behavior %0d problem: %s at %0t", beh, msg, $time);
      errs[beh]++;
   endtask

   // History of the previous edge
   initial prevReset = 1'b1;
   always @(posedge clk)
   begin
      prevPc    <= PC;
      prevReady <= PCReady;
      prevReset <= reset;
      if (!reset && MemWrite)
         storeIdx <= storeIdx + 1;
   end

   // Reset and first cycle after it
   resetPc: assert property (@(posedge clk) (reset || prevReset) |-> PC == 32'h0)
      else valueError(1, "PC", $sampled(PC), 32'h0);
   resetWr: assert property (@(posedge clk) (reset || prevReset) |-> !MemWrite)
      else valueError(1, "MemWrite", $sampled(MemWrite), 32'h0);
   resetStb: assert property (@(posedge clk) (reset || prevReset) |-> !MemStrobe)
      else valueError(1, "MemStrobe", $sampled(MemStrobe), 32'h0);

   // PC holds on a stall and steps by 4 on a retire
   pcHold: assert property (@(posedge clk) disable iff (reset)
         !prevReset && !prevReady |-> PC == prevPc)
      else valueError(2, "PC", $sampled(PC), $sampled(prevPc));
   pcStep: assert property (@(posedge clk) disable iff (reset)
         !prevReset && prevReady && !branchAt(prevPc) |-> PC == prevPc + 32'd4)
      else valueError(2, "PC", $sampled(PC), $sampled(prevPc) + 32'd4);

   // Every store against the table
   storeCount: assert property (@(posedge clk) disable iff (reset)
         MemWrite |-> storeIdx < numStores)
      else plainError(6, "more stores than the program holds");
   storeAddrOk: assert property (@(posedge clk) disable iff (reset)
         MemWrite && storeIdx < numStores |-> ALUResult == storeAddr[storeIdx])
      else valueError(storeBehavior[$sampled(storeIdx)], "ALUResult",
                      $sampled(ALUResult), storeAddr[$sampled(storeIdx)]);
   storeDataOk: assert property (@(posedge clk) disable iff (reset)
         MemWrite && storeIdx < numStores |-> WriteData == storeData[storeIdx])
      else valueError(storeBehavior[$sampled(storeIdx)], "WriteData",
                      $sampled(WriteData), storeData[$sampled(storeIdx)]);

   strobeOk: assert property (@(posedge clk) disable iff (reset)
         MemStrobe == memOpAt(PC))
      else valueError(4, "MemStrobe", $sampled(MemStrobe), memOpAt($sampled(PC)));

   // Branches
   beqTaken: assert property (@(posedge clk) disable iff (reset)
         prevReady && prevPc == 32'h58 |-> PC == 32'h64)
      else valueError(5, "PC", $sampled(PC), 32'h64);
   bneNotTaken: assert property (@(posedge clk) disable iff (reset)
         prevReady && prevPc == 32'h64 |-> PC == 32'h68)
      else valueError(5, "PC", $sampled(PC), 32'h68);
   skipNoWrite: assert property (@(posedge clk) disable iff (reset)
         (PC == 32'h5C || PC == 32'h60) |-> !MemWrite)
      else valueError(5, "MemWrite", $sampled(MemWrite), 32'h0);

   // Overflow conditions and the final loop
   vcNoWrite: assert property (@(posedge clk) disable iff (reset)
         PC == 32'h78 |-> !MemWrite)
      else valueError(6, "MemWrite", $sampled(MemWrite), 32'h0);
   loopHold: assert property (@(posedge clk) disable iff (reset)
         prevPc == 32'h7C && !prevReset |-> PC == 32'h7C)
      else valueError(6, "PC", $sampled(PC), 32'h7C);

   initial
   begin
      PCReady  = 1'b0;
      lfsr     = 16'd92;   // Seed
      storeIdx = 0;
      for (int i = 1; i <= 6; i++)
         errs[i] = 0;

      // Reset changes only near falling edges
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
      end
      while (reset !== 1'b0 && cycles < 20);
      if (reset !== 1'b0)
      begin
         $display("Timeout: reset never released");
         $display("Simulation failed");
         $finish;
      end

      // Random stalls until the program reaches its loop
      cycles = 0;
      while (PC !== 32'h7C && cycles < 600)
      begin
         @(negedge clk);
         PCReady = nextBit();   // Zero bit stalls one cycle
         cycles++;
      end
      if (PC !== 32'h7C)
      begin
         $display("Timeout: PC never reached the final loop, PC = %h", PC);
         $display("Simulation failed");
         $finish;
      end

      repeat (20)   // Dwell in the loop
      begin
         @(negedge clk);
         PCReady = nextBit();
      end

      if (storeIdx != numStores)
         plainError(3, $sformatf("only %0d of %0d stores seen", storeIdx, numStores));

      $display("Reset values: %0d errors", errs[1]);
      $display("PC hold and advance: %0d errors", errs[2]);
      $display("ALU results stored: %0d errors", errs[3]);
      $display("Load and store: %0d errors", errs[4]);
      $display("Conditional branches: %0d errors", errs[5]);
      $display("Overflow and final loop: %0d errors", errs[6]);

      total = 0;
      for (int i = 1; i <= 6; i++)
         total += errs[i];
      $display("Tests: 6, errors: %0d, stores: %0d", total, storeIdx);

      if (total == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== verification/tbClock.sv ====
`timescale 1ns/1ps

module tbClock
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // Rising edge at 1 ns resets the async flops before the first clock
   initial
   begin
      reset = 1'b0;
      #1;
      reset = 1'b1;
      repeat (5) @(posedge clk);   // Five cycles in reset
      @(negedge clk);
      reset = 1'b0;   // Released away from the rising edge
   end

endmodule

// ==== verification/tbMemory.sv ====
`timescale 1ns/1ps

module tbMemory
(
   input  logic        clk,
   input  logic [31:0] pc,
   input  logic [31:0] addr,
   input  logic [31:0] writeData,
   input  logic        memWrite,
   output logic [31:0] instr,
   output logic [31:0] readData
);

   logic [31:0] ram [0:63];

   // Word 48 is large enough that doubling it overflows
   initial
      for (int i = 0; i < 64; i++)
         ram[i] = 32'h7FFF_FF00 + i;

   // Test program
   always_comb
      case (pc)
         32'h00: instr = 32'hE200_0000;   // AND  R0, R0, #0
         32'h04: instr = 32'hE280_1005;   // ADD  R1, R0, #5
         32'h08: instr = 32'hE281_2003;   // ADD  R2, R1, #3
         32'h0C: instr = 32'hE242_3001;   // SUB  R3, R2, #1
         32'h10: instr = 32'hE081_4002;   // ADD  R4, R1, R2
         32'h14: instr = 32'hE042_5001;   // SUB  R5, R2, R1
         32'h18: instr = 32'hE202_600C;   // AND  R6, R2, #12
         32'h1C: instr = 32'hE003_7004;   // AND  R7, R3, R4
         32'h20: instr = 32'hE381_8010;   // ORR  R8, R1, #16
         32'h24: instr = 32'hE182_9003;   // ORR  R9, R2, R3
         32'h28: instr = 32'hE580_2000;   // STR  R2, [R0, #0]
         32'h2C: instr = 32'hE580_3004;
         32'h30: instr = 32'hE580_4008;
         32'h34: instr = 32'hE580_500C;
         32'h38: instr = 32'hE580_6010;
         32'h3C: instr = 32'hE580_7014;
         32'h40: instr = 32'hE580_8018;
         32'h44: instr = 32'hE580_901C;   // STR  R9, [R0, #28]
         32'h48: instr = 32'hE590_A008;   // LDR  R10, [R0, #8]
         32'h4C: instr = 32'hE28A_B064;   // ADD  R11, R10, #100
         32'h50: instr = 32'hE580_B020;   // STR  R11, [R0, #32]
         32'h54: instr = 32'hE251_C005;   // SUBS R12, R1, #5 sets Z
         32'h58: instr = 32'h0A00_0001;   // BEQ  to 0x64
         32'h5C: instr = 32'hE580_C024;   // Skipped store
         32'h60: instr = 32'hE580_C028;   // Skipped store
         32'h64: instr = 32'h1A00_0005;   // BNE  not taken
         32'h68: instr = 32'hE580_C02C;   // STR  R12, [R0, #44]
         32'h6C: instr = 32'hE590_D0C0;   // LDR  R13, [R0, #192]
         32'h70: instr = 32'hE09D_D00D;   // ADDS R13, R13, R13 overflows
         32'h74: instr = 32'h6580_D030;   // STRVS
         32'h78: instr = 32'h7580_D034;   // STRVC never executes
         32'h7C: instr = 32'hEAFF_FFFE;   // B to self
         default: instr = 32'hF000_0000;  // Condition 1111 never executes
      endcase

   assign readData = ram[addr[7:2]];

   always @(posedge clk)
      if (memWrite)
         ram[addr[7:2]] <= writeData;

endmodule
